//--- logic/tcp_rx_consts.svh
/*
  sizing constants for the tcp receive engine
  the reassembly window equals the buffer size, 2**TCP_RX_BUF_AW bytes
  the sack block count is fixed; blocks beyond it are forgotten
*/

`ifndef TCP_RX_CONSTS_SVH
`define TCP_RX_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// buffer and sequence sizing
////////////////////////////////////////////////////////////////////////////

// log2 of reassembly ram depth in bytes, also the receive window
`define TCP_RX_BUF_AW 8

// sack blocks held and reported, index 0 is the newest
`define TCP_RX_SACK_BLOCKS 4

// sequence and acknowledgement number width
`define TCP_RX_SEQ_W 32

`endif

//--- logic/tcp_rx_pkg.sv
/*
  shared types of the tcp receive engine
  sequence numbers wrap modulo 2**32, compare them through signed differences only
*/

`include "tcp_rx_consts.svh"

package tcp_rx_pkg;

  // sequence or acknowledgement number
  typedef logic [`TCP_RX_SEQ_W-1:0] tcp_num_t;

  // one sack block
  // left is the first byte seq, right is the seq after the last byte
  typedef struct packed {
    tcp_num_t left;
    tcp_num_t right;
  } sack_block_t;

  // sack merge fsm
  typedef enum logic [2:0] {
    st_idle,
    st_load,     // snapshot current sack list
    st_compare,  // overlap test of one old block against the new one
    st_join,     // widen new block or keep old block
    st_publish   // update loc_ack and sack outputs
  } merge_state_t;

endpackage

//--- logic/tcp_rx_window_check.sv
/*
  stage 1: port/ack filter and receive window check, evaluated on rx_sof
  header fields must be valid on the sof cycle; rx_len is at least 1
  seg_val pulses one cycle after sof, seg_store holds until the next sof
*/

`timescale 1ns/1ps
`include "tcp_rx_consts.svh"

module tcp_rx_window_check (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx_sof,
  input  tcp_rx_pkg::tcp_num_t rx_seq,
  input  logic [15:0]          rx_len,
  input  logic [15:0]          rx_src_port,
  input  logic [15:0]          rx_dst_port,
  input  logic [15:0]          loc_port,
  input  logic [15:0]          rem_port,
  input  logic                 rx_ack_flag,
  input  logic                 merge_busy,
  input  tcp_rx_pkg::tcp_num_t rd_ptr,
  output logic                 seg_val,
  output logic                 seg_store,
  output tcp_rx_pkg::tcp_num_t seg_left,
  output tcp_rx_pkg::tcp_num_t seg_right
);

  localparam tcp_rx_pkg::tcp_num_t win_bytes = 1 << `TCP_RX_BUF_AW;

  logic                 port_ok;
  logic                 seg_ok;
  tcp_rx_pkg::tcp_num_t right_seq;
  tcp_rx_pkg::tcp_num_t start_gap;
  tcp_rx_pkg::tcp_num_t stop_gap;

  // segment belongs to this connection
  assign port_ok = (rx_src_port == rem_port) && (rx_dst_port == loc_port);

  // a segment right behind the one being handed over counts as busy too
  assign seg_ok = rx_sof && port_ok && rx_ack_flag && !merge_busy && !seg_val;

  // seq after the last payload byte
  assign right_seq = rx_seq + tcp_rx_pkg::tcp_num_t'(rx_len);

  // both gaps must stay non-negative as signed values
  // start_gap: first byte not below the read pointer
  // stop_gap:  last byte still inside rd_ptr + buffer size
  assign start_gap = rx_seq - rd_ptr;
  assign stop_gap  = rd_ptr + win_bytes - right_seq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seg_val   <= 1'b0;
      seg_store <= 1'b0;
    end else begin
      seg_val <= seg_ok;
      // store flag held for the whole segment, buffer picks it up later
      if (rx_sof) begin
        seg_store <= seg_ok && !start_gap[31] && !stop_gap[31];
      end
    end
  end

  // borders only move for a segment that is handed over
  always_ff @(posedge clk) begin
    if (seg_ok) begin
      seg_left  <= rx_seq;
      seg_right <= right_seq;
    end
  end

endmodule

//--- logic/tcp_rx_sack_merge.sv
/*
  stage 2: sack list update and local ack tracking
  one segment at a time; segments offered while merge_busy are dropped upstream
  only four blocks are kept, on overflow the oldest block is lost
*/

`timescale 1ns/1ps
`include "tcp_rx_consts.svh"

module tcp_rx_sack_merge (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          init,
  input  tcp_rx_pkg::tcp_num_t          init_ack,
  input  logic                          seg_val,
  input  logic                          seg_store,
  input  tcp_rx_pkg::tcp_num_t          seg_left,
  input  tcp_rx_pkg::tcp_num_t          seg_right,
  output logic                          merge_busy,
  output tcp_rx_pkg::tcp_num_t          loc_ack,
  output tcp_rx_pkg::tcp_num_t          sack_left  [`TCP_RX_SACK_BLOCKS],
  output tcp_rx_pkg::tcp_num_t          sack_right [`TCP_RX_SACK_BLOCKS],
  output logic [`TCP_RX_SACK_BLOCKS-1:0] sack_pres
);

  localparam int nblk  = `TCP_RX_SACK_BLOCKS;
  localparam int idx_w = $clog2(nblk);

  tcp_rx_pkg::merge_state_t state;
  tcp_rx_pkg::sack_block_t  new_blk;          // incoming block, grows on joins
  tcp_rx_pkg::sack_block_t  cur_blk;          // old block under test
  tcp_rx_pkg::sack_block_t  work [nblk];      // snapshot of published list
  tcp_rx_pkg::sack_block_t  kept [nblk];      // old blocks not joined, in order
  tcp_rx_pkg::sack_block_t  pub  [nblk];      // published list
  logic [nblk-1:0]          work_pres;
  logic [nblk-1:0]          kept_pres;
  logic [idx_w:0]           kept_cnt;
  logic [idx_w-1:0]         idx;
  logic                     in_order;
  logic                     cat_ok;
  logic                     keep_new_left;
  logic                     keep_new_right;
  tcp_rx_pkg::tcp_num_t     start_dif;
  tcp_rx_pkg::tcp_num_t     stop_dif;
  tcp_rx_pkg::tcp_num_t     left_dif;
  tcp_rx_pkg::tcp_num_t     right_dif;

  ////////////////////////////////////////////////////////////////////////////
  // overlap test of work[idx] against the new block
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // old right not below new left, and new right not below old left
    // equal borders mean the blocks touch, which also joins them
    start_dif = work[idx].right - new_blk.left;
    stop_dif  = new_blk.right - work[idx].left;
    // sign bit set: new border lies outside the old block
    left_dif  = new_blk.left - work[idx].left;
    right_dif = work[idx].right - new_blk.right;
  end

  // published list to output ports
  always_comb begin
    for (int i = 0; i < nblk; i++) begin
      sack_left[i]  = pub[i].left;
      sack_right[i] = pub[i].right;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // merge fsm
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= tcp_rx_pkg::st_idle;
      merge_busy     <= 1'b0;
      loc_ack        <= '0;
      sack_pres      <= '0;
      pub            <= '{default: '0};
      work           <= '{default: '0};
      kept           <= '{default: '0};
      work_pres      <= '0;
      kept_pres      <= '0;
      kept_cnt       <= '0;
      idx            <= '0;
      new_blk        <= '0;
      cur_blk        <= '0;
      in_order       <= 1'b0;
      cat_ok         <= 1'b0;
      keep_new_left  <= 1'b0;
      keep_new_right <= 1'b0;
    end else if (init) begin
      // connection start, nothing received yet
      state      <= tcp_rx_pkg::st_idle;
      merge_busy <= 1'b0;
      loc_ack    <= init_ack;
      sack_pres  <= '0;
      pub        <= '{default: '0};
    end else begin
      case (state)
        tcp_rx_pkg::st_idle: begin
          if (seg_val && seg_store) begin
            new_blk    <= '{left: seg_left, right: seg_right};
            in_order   <= (seg_left == loc_ack);
            merge_busy <= 1'b1;
            state      <= tcp_rx_pkg::st_load;
          end
        end
        tcp_rx_pkg::st_load: begin
          work      <= pub;
          work_pres <= sack_pres;
          kept      <= '{default: '0};
          kept_pres <= '0;
          kept_cnt  <= '0;
          idx       <= '0;
          state     <= tcp_rx_pkg::st_compare;
        end
        tcp_rx_pkg::st_compare: begin
          cur_blk        <= work[idx];
          cat_ok         <= !start_dif[31] && !stop_dif[31];
          keep_new_left  <= left_dif[31];
          keep_new_right <= right_dif[31];
          if (work_pres[idx]) begin
            state <= tcp_rx_pkg::st_join;
          end else if (idx == idx_w'(nblk - 1)) begin
            // empty slot, skip straight on
            state <= tcp_rx_pkg::st_publish;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        tcp_rx_pkg::st_join: begin
          if (cat_ok) begin
            // old block is absorbed and freed
            new_blk.left  <= keep_new_left  ? new_blk.left  : cur_blk.left;
            new_blk.right <= keep_new_right ? new_blk.right : cur_blk.right;
          end else begin
            kept[kept_cnt[idx_w-1:0]]      <= cur_blk;
            kept_pres[kept_cnt[idx_w-1:0]] <= 1'b1;
            kept_cnt                       <= kept_cnt + 1'b1;
          end
          if (idx == idx_w'(nblk - 1)) begin
            state <= tcp_rx_pkg::st_publish;
          end else begin
            idx   <= idx + 1'b1;
            state <= tcp_rx_pkg::st_compare;
          end
        end
        tcp_rx_pkg::st_publish: begin
          if (in_order) begin
            // hole filled, ack moves to the merged right border
            loc_ack   <= new_blk.right;
            pub       <= kept;
            sack_pres <= kept_pres;
          end else begin
            // newest block first, the last kept block falls off
            pub[0] <= new_blk;
            for (int i = 1; i < nblk; i++) begin
              pub[i] <= kept[i-1];
            end
            sack_pres <= {kept_pres[nblk-2:0], 1'b1};
          end
          merge_busy <= 1'b0;
          state      <= tcp_rx_pkg::st_idle;
        end
        default: begin
          state <= tcp_rx_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

//--- logic/tcp_rx_reassembly_buf.sv
/*
  stage 3: reassembly ram, 2**TCP_RX_BUF_AW bytes addressed by seq modulo size
  incoming bytes are written 2 cycles after arrival; one byte out per cycle
  data_val follows each read pointer step by 2 cycles
*/

`timescale 1ns/1ps
`include "tcp_rx_consts.svh"

module tcp_rx_reassembly_buf (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 init,
  input  tcp_rx_pkg::tcp_num_t init_ack,
  input  logic                 rx_val,
  input  logic                 rx_sof,
  input  logic [7:0]           rx_dat,
  input  logic                 seg_store,
  input  tcp_rx_pkg::tcp_num_t seg_left,
  input  tcp_rx_pkg::tcp_num_t loc_ack,
  output tcp_rx_pkg::tcp_num_t rd_ptr,
  output logic                 data_val,
  output logic [7:0]           data_dat
);

  localparam int aw = `TCP_RX_BUF_AW;

  logic [7:0]    mem [2**aw];
  logic          d1_val;
  logic          d1_sof;
  logic [7:0]    d1_dat;
  logic          d2_val;
  logic [7:0]    d2_dat;
  logic [aw-1:0] wr_ptr;
  logic          wr_on;
  logic          rd_step;
  logic [7:0]    rd_q;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // 2 stage delay gives the window check time to classify the segment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d1_val <= 1'b0;
      d1_sof <= 1'b0;
      d2_val <= 1'b0;
      wr_on  <= 1'b0;
    end else begin
      d1_val <= rx_val;
      d1_sof <= rx_sof && rx_val;
      d2_val <= d1_val;
      // store decision is valid while the first byte sits in stage 1
      if (d1_sof) begin
        wr_on <= seg_store;
      end
    end
  end

  always_ff @(posedge clk) begin
    d1_dat <= rx_dat;
    d2_dat <= d1_dat;
    // first byte lands at seg_left, the rest follow
    if (d1_sof) begin
      wr_ptr <= seg_left[aw-1:0];
    end else if (d2_val) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
    if (d2_val && wr_on) begin
      mem[wr_ptr] <= d2_dat;
    end
    // read returns the old byte on a same-address write
    rd_q     <= mem[rd_ptr[aw-1:0]];
    data_dat <= rd_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  // walk up to loc_ack, every step releases the byte at rd_ptr
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr   <= '0;
      rd_step  <= 1'b0;
      data_val <= 1'b0;
    end else begin
      data_val <= rd_step;
      if (init) begin
        rd_ptr  <= init_ack;
        rd_step <= 1'b0;
      end else begin
        rd_step <= (rd_ptr != loc_ack);
        if (rd_ptr != loc_ack) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/tcp_rx_top.sv
/*
  tcp receive engine: window check, sack merge, reassembly buffer
  no back-pressure; rejected or busy-time segments are dropped silently
  accepted segments need at least 12 cycles between sof pulses
*/

`timescale 1ns/1ps
`include "tcp_rx_consts.svh"

module tcp_rx_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // payload stream, sof on first byte
  input  logic                          rx_val,
  input  logic                          rx_sof,
  input  logic [7:0]                    rx_dat,
  // header fields, valid with sof
  input  tcp_rx_pkg::tcp_num_t          rx_seq,
  input  logic [15:0]                   rx_len,
  input  logic [15:0]                   rx_src_port,
  input  logic [15:0]                   rx_dst_port,
  input  logic                          rx_ack_flag,
  // connection
  input  logic [15:0]                   loc_port,
  input  logic [15:0]                   rem_port,
  input  logic                          init,
  input  tcp_rx_pkg::tcp_num_t          init_ack,
  // status and user stream
  output tcp_rx_pkg::tcp_num_t          loc_ack,
  output logic                          data_val,
  output logic [7:0]                    data_dat,
  output tcp_rx_pkg::tcp_num_t          sack_left  [`TCP_RX_SACK_BLOCKS],
  output tcp_rx_pkg::tcp_num_t          sack_right [`TCP_RX_SACK_BLOCKS],
  output logic [`TCP_RX_SACK_BLOCKS-1:0] sack_pres
);

  logic                 seg_val;
  logic                 seg_store;
  logic                 merge_busy;
  tcp_rx_pkg::tcp_num_t seg_left;
  tcp_rx_pkg::tcp_num_t seg_right;
  tcp_rx_pkg::tcp_num_t rd_ptr;

  tcp_rx_window_check u_window (
    .clk(clk), .rst_n(rst_n),
    .rx_sof(rx_sof), .rx_seq(rx_seq), .rx_len(rx_len),
    .rx_src_port(rx_src_port), .rx_dst_port(rx_dst_port),
    .loc_port(loc_port), .rem_port(rem_port),
    .rx_ack_flag(rx_ack_flag), .merge_busy(merge_busy), .rd_ptr(rd_ptr),
    .seg_val(seg_val), .seg_store(seg_store),
    .seg_left(seg_left), .seg_right(seg_right)
  );

  tcp_rx_sack_merge u_merge (
    .clk(clk), .rst_n(rst_n), .init(init), .init_ack(init_ack),
    .seg_val(seg_val), .seg_store(seg_store),
    .seg_left(seg_left), .seg_right(seg_right),
    .merge_busy(merge_busy), .loc_ack(loc_ack),
    .sack_left(sack_left), .sack_right(sack_right), .sack_pres(sack_pres)
  );

  tcp_rx_reassembly_buf u_buf (
    .clk(clk), .rst_n(rst_n), .init(init), .init_ack(init_ack),
    .rx_val(rx_val), .rx_sof(rx_sof), .rx_dat(rx_dat),
    .seg_store(seg_store), .seg_left(seg_left), .loc_ack(loc_ack),
    .rd_ptr(rd_ptr), .data_val(data_val), .data_dat(data_dat)
  );

endmodule

//--- test/tcp_rx_tb.sv
/*
  testbench for the tcp receive engine
  init ack 32'h1000_00f0 makes the window wrap the ram address
  segments are 16 idle cycles apart and output is drained before the next one
  so the model takes rd_ptr equal to loc_ack and never sees merge_busy
*/

`timescale 1ns/1ps
`include "tcp_rx_consts.svh"

module tcp_rx_tb;

  localparam int          nblk     = `TCP_RX_SACK_BLOCKS;
  localparam logic [15:0] loc_p    = 16'h1f90;
  localparam logic [15:0] rem_p    = 16'hc350;
  localparam logic [31:0] base_ack = 32'h1000_00f0;

  // expected engine state after a segment
  typedef struct packed {
    logic [31:0]           ack;
    logic [nblk-1:0]       pres;
    logic [nblk-1:0][31:0] left;
    logic [nblk-1:0][31:0] right;
  } model_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 rx_val;
  logic                 rx_sof;
  logic [7:0]           rx_dat;
  tcp_rx_pkg::tcp_num_t rx_seq;
  logic [15:0]          rx_len;
  logic [15:0]          rx_src_port;
  logic [15:0]          rx_dst_port;
  logic                 rx_ack_flag;
  logic [15:0]          loc_port;
  logic [15:0]          rem_port;
  logic                 init;
  tcp_rx_pkg::tcp_num_t init_ack;
  tcp_rx_pkg::tcp_num_t loc_ack;
  logic                 data_val;
  logic [7:0]           data_dat;
  tcp_rx_pkg::tcp_num_t sack_left  [nblk];
  tcp_rx_pkg::tcp_num_t sack_right [nblk];
  logic [nblk-1:0]      sack_pres;

  model_t               exp_st;
  tcp_rx_pkg::tcp_num_t next_seq = '0;   // seq of the next byte expected on data_val
  integer               seed = 32'hecb0;
  int                   err_cnt = 0;
  int                   check_cnt = 0;
  event                 seg_done;

  tcp_rx_top u_dut (
    .clk(clk), .rst_n(rst_n),
    .rx_val(rx_val), .rx_sof(rx_sof), .rx_dat(rx_dat),
    .rx_seq(rx_seq), .rx_len(rx_len),
    .rx_src_port(rx_src_port), .rx_dst_port(rx_dst_port), .rx_ack_flag(rx_ack_flag),
    .loc_port(loc_port), .rem_port(rem_port), .init(init), .init_ack(init_ack),
    .loc_ack(loc_ack), .data_val(data_val), .data_dat(data_dat),
    .sack_left(sack_left), .sack_right(sack_right), .sack_pres(sack_pres)
  );

  // 100 ns period
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  // window filter and then join every block that overlaps or touches the new one
  function automatic model_t sack_model(input model_t cur, input logic [31:0] seq,
                                        input logic [15:0] len, input logic hdr_ok);
    model_t      nxt;
    model_t      kept;
    logic [31:0] nl;
    logic [31:0] nr;
    logic [31:0] d_lo;
    logic [31:0] d_hi;
    int          kn;
    nxt  = cur;
    kept = '0;
    kn   = 0;
    nl   = seq;
    nr   = seq + 32'(len);
    // start not below the read pointer and end inside read pointer + buffer size
    d_lo = nl - cur.ack;
    d_hi = cur.ack + (32'd1 << `TCP_RX_BUF_AW) - nr;
    if (hdr_ok && !d_lo[31] && !d_hi[31]) begin
      for (int i = 0; i < nblk; i++) begin
        if (cur.pres[i]) begin
          d_lo = cur.right[i] - nl;
          d_hi = nr - cur.left[i];
          if (!d_lo[31] && !d_hi[31]) begin
            // widen to the union
            d_lo = cur.left[i] - nl;
            d_hi = cur.right[i] - nr;
            if (d_lo[31]) begin
              nl = cur.left[i];
            end
            if (!d_hi[31]) begin
              nr = cur.right[i];
            end
          end else begin
            kept.left[kn]  = cur.left[i];
            kept.right[kn] = cur.right[i];
            kept.pres[kn]  = 1'b1;
            kn++;
          end
        end
      end
      if (seq == cur.ack) begin
        nxt     = kept;
        nxt.ack = nr;
      end else begin
        // newest goes to slot 0 and the last kept block falls off
        nxt.left  = {kept.left[nblk-2:0], nl};
        nxt.right = {kept.right[nblk-2:0], nr};
        nxt.pres  = {kept.pres[nblk-2:0], 1'b1};
      end
    end
    return nxt;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic end_run;
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  // drive one segment one byte per cycle with header fields only on sof
  task automatic send_seg(input logic [31:0] seq, input logic [15:0] len,
                          input logic [15:0] src, input logic [15:0] dst,
                          input logic ack_f);
    for (int i = 0; i < int'(len); i++) begin
      @(posedge clk);
      #1;
      rx_val = 1'b1;
      rx_sof = (i == 0);
      rx_dat = 8'(seq + 32'(i)) ^ 8'h5a;
      if (i == 0) begin
        rx_seq      = seq;
        rx_len      = len;
        rx_src_port = src;
        rx_dst_port = dst;
        rx_ack_flag = ack_f;
      end else begin
        rx_seq = $random(seed);
        rx_len = 16'($random(seed));
      end
    end
    @(posedge clk);
    #1;
    rx_val = 1'b0;
    rx_sof = 1'b0;
    rx_dat = 8'($random(seed));
  endtask

  // data_val low for 4 cycles in a row
  task automatic wait_quiet;
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < 4 && cycles < 1000) begin
      @(negedge clk);
      quiet = data_val ? 0 : quiet + 1;
      cycles++;
    end
    if (quiet < 4) begin
      err_cnt++;
      $display("timeout at %0t ns: data_val never went quiet after a segment", $time);
      end_run();
    end
  endtask

  task automatic run_seg(input logic [31:0] seq, input logic [15:0] len,
                         input logic [15:0] src, input logic [15:0] dst,
                         input logic ack_f);
    exp_st = sack_model(exp_st, seq, len, (src == rem_p) && (dst == loc_p) && ack_f);
    send_seg(seq, len, src, dst, ack_f);
    // merge finishes well inside the idle gap
    repeat (16) @(posedge clk);
    wait_quiet();
    #1;
    ->seg_done;
    // compare process samples before the expected state moves on
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////////////////////

  // every released byte carries its own seq in order
  always @(negedge clk) begin
    if (init) begin
      next_seq = init_ack;
    end else if (data_val) begin
      check_val(32'(data_dat), 32'(next_seq[7:0] ^ 8'h5a), "data_dat byte");
      next_seq = next_seq + 1;
    end
  end

  always @(seg_done) begin
    check_val(loc_ack, exp_st.ack, "loc_ack");
    check_val(32'(sack_pres), 32'(exp_st.pres), "sack_pres");
    for (int i = 0; i < nblk; i++) begin
      if (exp_st.pres[i]) begin
        check_val(sack_left[i], exp_st.left[i], $sformatf("sack_left[%0d]", i));
        check_val(sack_right[i], exp_st.right[i], $sformatf("sack_right[%0d]", i));
      end
    end
    // released exactly up to loc_ack
    check_val(next_seq, exp_st.ack, "bytes released");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] b;
    logic [15:0] l1;
    logic [15:0] l2;
    logic [15:0] l3;
    rst_n       = 1'b0;
    rx_val      = 1'b0;
    rx_sof      = 1'b0;
    rx_dat      = 8'h00;
    rx_seq      = '0;
    rx_len      = 16'd0;
    rx_src_port = 16'd0;
    rx_dst_port = 16'd0;
    rx_ack_flag = 1'b0;
    loc_port    = loc_p;
    rem_port    = rem_p;
    init        = 1'b0;
    init_ack    = '0;
    exp_st      = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    init     = 1'b1;
    init_ack = base_ack;
    @(posedge clk);
    #1;
    init       = 1'b0;
    exp_st.ack = base_ack;
    repeat (4) @(posedge clk);

    // in-order stream of three random-length segments
    b  = exp_st.ack;
    l1 = 16'(1 + ({$random(seed)} % 40));
    l2 = 16'(1 + ({$random(seed)} % 40));
    l3 = 16'(1 + ({$random(seed)} % 40));
    run_seg(b, l1, rem_p, loc_p, 1'b1);
    run_seg(b + l1, l2, rem_p, loc_p, 1'b1);
    run_seg(b + l1 + l2, l3, rem_p, loc_p, 1'b1);

    // two blocks above loc_ack and then a hole fill that covers both
    b = exp_st.ack;
    run_seg(b + 10, 20, rem_p, loc_p, 1'b1);
    run_seg(b + 50, 20, rem_p, loc_p, 1'b1);
    run_seg(b, 50, rem_p, loc_p, 1'b1);

    // new segment touches [20,30) and overlaps [40,50)
    b = exp_st.ack;
    run_seg(b + 20, 10, rem_p, loc_p, 1'b1);
    run_seg(b + 40, 10, rem_p, loc_p, 1'b1);
    run_seg(b + 70, 10, rem_p, loc_p, 1'b1);
    run_seg(b + 100, 10, rem_p, loc_p, 1'b1);
    run_seg(b + 30, 15, rem_p, loc_p, 1'b1);
    run_seg(b, 110, rem_p, loc_p, 1'b1);

    // five disjoint blocks where the oldest is forgotten
    b = exp_st.ack;
    for (int k = 0; k < 5; k++) begin
      run_seg(b + 10 + 20 * k, 10, rem_p, loc_p, 1'b1);
    end
    run_seg(b, 10, rem_p, loc_p, 1'b1);
    run_seg(b + 10, 100, rem_p, loc_p, 1'b1);

    // wrong source port, wrong destination port, no ack flag
    // below the window, beyond the window and then a good one
    b = exp_st.ack;
    run_seg(b, 10, rem_p ^ 16'h0001, loc_p, 1'b1);
    run_seg(b, 10, rem_p, loc_p ^ 16'h0001, 1'b1);
    run_seg(b, 10, rem_p, loc_p, 1'b0);
    run_seg(b - 5, 10, rem_p, loc_p, 1'b1);
    run_seg(b + 250, 10, rem_p, loc_p, 1'b1);
    run_seg(b, 10, rem_p, loc_p, 1'b1);

    end_run();
  end

endmodule

//--- compile.f
+incdir+logic
logic/tcp_rx_pkg.sv
logic/tcp_rx_window_check.sv
logic/tcp_rx_sack_merge.sv
logic/tcp_rx_reassembly_buf.sv
logic/tcp_rx_top.sv
test/tcp_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tcp receive testbench with verilator, all output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tcp_rx_tb -f compile.f \
  -o tcp_rx_sim > sim.log 2>&1 &&
  ./obj_dir/tcp_rx_sim >> sim.log 2>&1 ||
  { echo "build or simulation error, see sim.log"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
echo "PASS"
